/* Bender.yml */
package:
  name: adc_if

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/adc_if_pkg.sv
      - verilog/adc_cfg_if.sv
      - verilog/adc_reg_bank.sv
      - verilog/adc_cnv_timing.sv
      - verilog/adc_lane_deser.sv
      - verilog/adc_if_top.sv

  - target: test
    include_dirs:
      - verilog
    files:
      - testbench/tb_clk_gen.sv
      - testbench/adc_if_tb.sv

/* files.f */
+incdir+verilog
verilog/adc_if_pkg.sv
verilog/adc_cfg_if.sv
verilog/adc_reg_bank.sv
verilog/adc_cnv_timing.sv
verilog/adc_lane_deser.sv
verilog/adc_if_top.sv
testbench/tb_clk_gen.sv
testbench/adc_if_tb.sv

/* testbench/adc_if_tb.sv */
// testbench of the SAR ADC capture core
// all stimulus changes on the falling edge, all checks sample there too
// the ADC lane model draws one random word per cnv from a fixed seed
// expected words and timing come from the register map and lane rules
// stops at the first mismatch

`include "adc_if_params.svh"

module adc_if_tb
  import adc_if_pkg::*;
();

  localparam int RES        = `ADC_RESOLUTION;
  localparam int CLK_PERIOD = 100;

  // register map
  localparam reg_addr_t A_CTRL    = reg_addr_t'(0);
  localparam reg_addr_t A_PERIOD  = reg_addr_t'(1);
  localparam reg_addr_t A_DELAY   = reg_addr_t'(2);
  localparam reg_addr_t A_COUNT   = reg_addr_t'(3);
  localparam reg_addr_t A_LAST    = reg_addr_t'(4);
  localparam reg_addr_t A_VERSION = reg_addr_t'(5);

  // random timing stays inside cnv_period > conv_delay + nbits + 2
  localparam int MAX_DELAY     = 8;
  localparam int MIN_SLACK     = 5;
  localparam int PERIOD_SPREAD = 16;
  localparam int MAX_PERIOD    = MAX_DELAY + RES + MIN_SLACK + PERIOD_SPREAD - 1;

  // conversions per phase
  localparam int N_ONE    = 6;
  localparam int N_TWO    = 6;
  localparam int N_ROUNDS = 4;
  localparam int N_RAND   = 4;
  // last term covers the mid-run stop, then an allowance per phase for register traffic
  localparam int N_CONV_TOTAL = N_ONE + N_TWO + N_ROUNDS * N_RAND + 3 + (N_ROUNDS + 3) * 4;
  localparam longint WATCHDOG_TIME = longint'(N_CONV_TOTAL * MAX_PERIOD + 200) * CLK_PERIOD;

  logic        s_axi_aclk;
  logic        rst_n;
  logic        reg_wr;
  logic        reg_rd;
  reg_addr_t   reg_addr;
  reg_data_t   reg_wdata;
  reg_data_t   reg_rdata;
  logic        reg_rvalid;
  logic        cnv;
  logic        clk_gate;
  logic        da;
  logic        db;
  logic        adc_valid;
  adc_sample_t adc_data;

  integer      seed = 26;
  adc_sample_t expected[$];
  adc_sample_t last_expected = '0;

  // reference model state, set by the test sequence
  bit          exp_enable = 1'b0;
  logic        cur_two = 1'b0;
  cycle_cnt_t  cur_period = cycle_cnt_t'(`DEF_CNV_PERIOD);
  cycle_cnt_t  cur_delay = cycle_cnt_t'(`DEF_CONV_DELAY);
  int          cur_nbits = RES;

  // monitor state
  int          cyc = 0;
  int          last_cnv_cyc = 0;
  int          gate_len = 0;
  int          valid_seen = 0;
  int          cleared_at = 0;
  bit          cnv_seen = 1'b0;
  bit          armed = 1'b0;
  bit          gate_prev = 1'b0;

  tb_clk_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(5)) i_clk_gen (
    .s_axi_aclk (s_axi_aclk),
    .rst_n      (rst_n)
  );

  adc_if_top dut (
    .s_axi_aclk (s_axi_aclk),
    .rst_n      (rst_n),
    .reg_wr     (reg_wr),
    .reg_rd     (reg_rd),
    .reg_addr   (reg_addr),
    .reg_wdata  (reg_wdata),
    .reg_rdata  (reg_rdata),
    .reg_rvalid (reg_rvalid),
    .cnv        (cnv),
    .clk_gate   (clk_gate),
    .da         (da),
    .db         (db),
    .adc_valid  (adc_valid),
    .adc_data   (adc_data)
  );

  // ***************************************************************************
  // failure reporting and compare tasks
  // ***************************************************************************

  task automatic stop_with_failure();
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic abort_run(input string why);
    $display("%s at time %0t", why, $time);
    stop_with_failure();
  endtask

  task automatic compare_sample(input string name, input adc_sample_t got, input adc_sample_t exp);
    if (got !== exp) begin
      $display("ERROR at %0t: %s = %h, expected %h", $time, name, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic compare_reg(input string name, input reg_data_t got, input reg_data_t exp);
    if (got !== exp) begin
      $display("ERROR at %0t: %s = %h, expected %h", $time, name, got, exp);
      stop_with_failure();
    end
  endtask

  // intervals counted in clock cycles
  task automatic compare_cycles(input string name, input cycle_cnt_t got, input cycle_cnt_t exp);
    if (got !== exp) begin
      $display("ERROR at %0t: %s = %0d, expected %0d", $time, name, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERROR at %0t: %s = %b, expected %b", $time, name, got, exp);
      stop_with_failure();
    end
  endtask

  // ***************************************************************************
  // register port access
  // ***************************************************************************

  task automatic reg_write(input reg_addr_t addr, input reg_data_t data);
    @(negedge s_axi_aclk);
    reg_wr    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    @(negedge s_axi_aclk);
    reg_wr = 1'b0;
  endtask

  // data and reg_rvalid are due exactly one cycle after the strobe
  task automatic reg_read(input reg_addr_t addr, output reg_data_t data);
    @(negedge s_axi_aclk);
    reg_rd   = 1'b1;
    reg_addr = addr;
    @(negedge s_axi_aclk);
    reg_rd = 1'b0;
    compare_bit("reg_rvalid", reg_rvalid, 1'b1);
    data = reg_rdata;
    @(negedge s_axi_aclk);
    compare_bit("reg_rvalid", reg_rvalid, 1'b0);
  endtask

  task automatic check_reg(input reg_addr_t addr, input reg_data_t exp, input string name);
    reg_data_t got;
    reg_read(addr, got);
    compare_reg(name, got, exp);
  endtask

  // count since last clear and latest model word, then clear by any write
  task automatic check_counts();
    check_reg(A_COUNT, reg_data_t'(valid_seen - cleared_at), "sample_count");
    check_reg(A_LAST, reg_data_t'(last_expected), "last_sample");
    reg_write(A_COUNT, reg_data_t'($random(seed)));
    check_reg(A_COUNT, '0, "sample_count");
    cleared_at = valid_seen;
  endtask

  // ***************************************************************************
  // ADC lane model
  // ***************************************************************************

  // new word per cnv, one bit per lane on each falling edge inside the gate
  // lines idle high so stray captures would show up in the word
  initial begin : adc_lane_model
    adc_sample_t word;
    int          bit_idx;
    da      = 1'b1;
    db      = 1'b1;
    word    = '0;
    bit_idx = 0;
    forever begin
      @(negedge s_axi_aclk);
      if (cnv === 1'b1) begin
        word    = adc_sample_t'($random(seed));
        bit_idx = 0;
        expected.push_back(word);
      end
      if (clk_gate === 1'b1) begin
        if (cur_two) begin
          // odd positions on da, even ones on db, MSB pair first
          da = word[RES-1-2*bit_idx];
          db = word[RES-2-2*bit_idx];
        end else begin
          da = word[RES-1-bit_idx];
          db = 1'b1;
        end
        bit_idx++;
      end else begin
        da = 1'b1;
        db = 1'b1;
      end
    end
  end

  // ***************************************************************************
  // timing and data monitor
  // ***************************************************************************

  always @(negedge s_axi_aclk) begin
    cyc = cyc + 1;
    if (rst_n) begin
      if (cnv === 1'b1) begin
        if (!exp_enable) abort_run("cnv issued while the core is disabled");
        if (armed) abort_run("cnv issued before the previous readout finished");
        if (cnv_seen) begin
          compare_cycles("cnv_period", cycle_cnt_t'(cyc - last_cnv_cyc), cur_period);
        end
        cnv_seen     = 1'b1;
        armed        = 1'b1;
        last_cnv_cyc = cyc;
      end
      if (clk_gate === 1'b1 && !gate_prev) begin
        if (!armed) abort_run("clk_gate opened without a conversion start");
        compare_cycles("conv_delay", cycle_cnt_t'(cyc - last_cnv_cyc), cur_delay);
        gate_len = 0;
      end
      if (clk_gate === 1'b1) gate_len++;
      if (clk_gate !== 1'b1 && gate_prev) begin
        compare_cycles("clk_gate width", cycle_cnt_t'(gate_len), cycle_cnt_t'(cur_nbits));
      end
      if (adc_valid === 1'b1) begin
        if (!armed || expected.size() == 0) abort_run("adc_valid without a pending sample");
        // fixed latency from cnv
        compare_cycles("adc_valid latency", cycle_cnt_t'(cyc - last_cnv_cyc),
                       cycle_cnt_t'(cur_delay + cur_nbits + 1));
        last_expected = expected.pop_front();
        compare_sample("adc_data", adc_data, last_expected);
        valid_seen++;
        armed = 1'b0;
      end
      gate_prev = (clk_gate === 1'b1);
    end
  end

  // ***************************************************************************
  // test phases
  // ***************************************************************************

  // random delay and a period that leaves room for the readout
  task automatic pick_timing(input logic two, output cycle_cnt_t period,
                             output cycle_cnt_t delay);
    int nbits;
    nbits  = two ? RES / 2 : RES;
    delay  = cycle_cnt_t'(1 + $unsigned($random(seed)) % MAX_DELAY);
    period = cycle_cnt_t'(delay + nbits + MIN_SLACK + $unsigned($random(seed)) % PERIOD_SPREAD);
  endtask

  // configure while idle, enable, collect n_conv samples, disable
  task automatic run_phase(input logic two, input int n_conv, input cycle_cnt_t period,
                           input cycle_cnt_t delay);
    int target;
    reg_write(A_PERIOD, reg_data_t'(period));
    reg_write(A_DELAY, reg_data_t'(delay));
    check_reg(A_PERIOD, reg_data_t'(period), "cnv_period");
    check_reg(A_DELAY, reg_data_t'(delay), "conv_delay");
    cur_two    = two;
    cur_period = period;
    cur_delay  = delay;
    cur_nbits  = two ? RES / 2 : RES;
    cnv_seen   = 1'b0;
    exp_enable = 1'b1;
    target     = valid_seen + n_conv;
    reg_write(A_CTRL, reg_data_t'({two, 1'b1}));
    // first pulse one cycle after enable took effect
    compare_bit("cnv", cnv, 1'b0);
    @(negedge s_axi_aclk);
    compare_bit("cnv", cnv, 1'b1);
    while (valid_seen < target) @(negedge s_axi_aclk);
    reg_write(A_CTRL, reg_data_t'({two, 1'b0}));
    exp_enable = 1'b0;
    check_reg(A_CTRL, reg_data_t'({two, 1'b0}), "ctrl");
  endtask

  // disable inside a readout, the word still arrives, then silence
  task automatic disable_mid_run();
    int target;
    cnv_seen   = 1'b0;
    exp_enable = 1'b1;
    target     = valid_seen + 1;
    reg_write(A_CTRL, reg_data_t'({cur_two, 1'b1}));
    while (clk_gate !== 1'b1) @(negedge s_axi_aclk);
    reg_write(A_CTRL, reg_data_t'({cur_two, 1'b0}));
    exp_enable = 1'b0;
    while (valid_seen < target) @(negedge s_axi_aclk);
    // monitor flags any cnv or gate in this window
    repeat (2 * int'(cur_period)) @(negedge s_axi_aclk);
    compare_bit("clk_gate", clk_gate, 1'b0);
  endtask

  // ***************************************************************************
  // main sequence and watchdog
  // ***************************************************************************

  initial begin : test_sequence
    logic       two;
    cycle_cnt_t period;
    cycle_cnt_t delay;
    reg_wr    = 1'b0;
    reg_rd    = 1'b0;
    reg_addr  = '0;
    reg_wdata = '0;
    @(posedge rst_n);
    // quiet outputs and reset values
    repeat (4) begin
      @(negedge s_axi_aclk);
      compare_bit("cnv", cnv, 1'b0);
      compare_bit("clk_gate", clk_gate, 1'b0);
      compare_bit("adc_valid", adc_valid, 1'b0);
      compare_bit("reg_rvalid", reg_rvalid, 1'b0);
    end
    check_reg(A_CTRL, '0, "ctrl");
    check_reg(A_PERIOD, reg_data_t'(`DEF_CNV_PERIOD), "cnv_period");
    check_reg(A_DELAY, reg_data_t'(`DEF_CONV_DELAY), "conv_delay");
    check_reg(A_COUNT, '0, "sample_count");
    check_reg(A_LAST, '0, "last_sample");
    check_reg(A_VERSION, reg_data_t'(`CORE_VERSION), "version");
    check_reg(reg_addr_t'(6), '0, "unmapped");
    check_reg(reg_addr_t'(15), '0, "unmapped");

    // one lane at reset timing
    run_phase(1'b0, N_ONE, cycle_cnt_t'(`DEF_CNV_PERIOD), cycle_cnt_t'(`DEF_CONV_DELAY));
    check_counts();

    // two lanes with random timing
    pick_timing(1'b1, period, delay);
    run_phase(1'b1, N_TWO, period, delay);
    check_counts();

    // random lane mode and timing per round
    for (int r = 0; r < N_ROUNDS; r++) begin
      two = 1'($random(seed));
      pick_timing(two, period, delay);
      run_phase(two, N_RAND, period, delay);
    end
    check_counts();

    disable_mid_run();
    check_counts();

    if (expected.size() != 0) begin
      abort_run("model samples left without a matching adc_valid");
    end else begin
      $display("Everything OK");
      $finish;
    end
  end

  initial begin : watchdog
    #(WATCHDOG_TIME);
    abort_run("watchdog expired before the test sequence completed");
  end

endmodule

/* testbench/tb_clk_gen.sv */
// clock and reset source for the capture core testbench
// reset is released on a falling edge, after RESET_CYCLES rising edges

module tb_clk_gen #(
  parameter int PERIOD       = 100,
  parameter int RESET_CYCLES = 5
) (
  output logic s_axi_aclk,
  output logic rst_n
);

  // free-running clock, starts low
  initial begin
    s_axi_aclk = 1'b0;
    forever #(PERIOD / 2) s_axi_aclk = ~s_axi_aclk;
  end

  // reset held for a fixed number of cycles
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge s_axi_aclk);
    @(negedge s_axi_aclk);
    rst_n = 1'b1;
  end

endmodule

/* verilog/adc_cfg_if.sv */
// live configuration from the register bank to the datapath
// values are quasi-static, software changes them only while disabled
// or between conversions

interface adc_cfg_if
  import adc_if_pkg::*;
();

  // run control
  logic       enable;
  // 0 = da only, 1 = da and db interleaved
  logic       two_lanes;
  // cycles between conversion starts
  cycle_cnt_t cnv_period;
  // cycles from cnv to gate opening
  cycle_cnt_t conv_delay;

  // register bank owns the values
  modport reg_side (
    output enable,
    output two_lanes,
    output cnv_period,
    output conv_delay
  );

  // timing block and deserializer only look
  modport timing_side (
    input enable,
    input two_lanes,
    input cnv_period,
    input conv_delay
  );

endinterface

/* verilog/adc_cnv_timing.sv */
// conversion start and clock-gate timing of the capture core
// conv_delay must be at least 1, gate never opens in the cnv cycle
// software keeps cnv_period > conv_delay + nbits + 2
// a cnv that arrives outside IDLE is ignored by the readout and flagged

`include "adc_if_params.svh"

module adc_cnv_timing
  import adc_if_pkg::*;
(
  input  logic           s_axi_aclk,
  input  logic           rst_n,
  adc_cfg_if.timing_side cfg,
  output logic           cnv,
  output logic           gate
);

  localparam int NBITS     = `ADC_RESOLUTION;
  localparam int BIT_CNT_W = $clog2(NBITS);

  cycle_cnt_t             period_cnt;
  cycle_cnt_t             delay_cnt;
  logic [BIT_CNT_W-1:0]   bit_cnt;
  logic [BIT_CNT_W-1:0]   last_bit;
  logic                   cnv_start;
  readout_state_t         state;

  // ***********************************************************************
  // conversion period
  // ***********************************************************************

  // counter parks at zero while disabled, so the first start comes
  // right after enable is set
  assign cnv_start = cfg.enable && (period_cnt == '0);

  always_ff @(posedge s_axi_aclk or negedge rst_n) begin
    if (!rst_n) begin
      period_cnt <= '0;
      cnv        <= 1'b0;
    end else begin
      // one-cycle pulse
      cnv <= cnv_start;
      if (!cfg.enable) begin
        period_cnt <= '0;
      end else if (cnv_start) begin
        period_cnt <= cfg.cnv_period - 1'b1;
      end else begin
        period_cnt <= period_cnt - 1'b1;
      end
    end
  end

  // ***********************************************************************
  // readout sequencer
  // ***********************************************************************

  // gated cycles per sample minus one
  assign last_bit = cfg.two_lanes ? BIT_CNT_W'(NBITS / 2 - 1) : BIT_CNT_W'(NBITS - 1);

  // runs on its own once started, clearing enable lets a readout finish
  always_ff @(posedge s_axi_aclk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= IDLE;
      delay_cnt <= '0;
      bit_cnt   <= '0;
      gate      <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (cnv_start) begin
            state     <= CONVERT;
            delay_cnt <= cfg.conv_delay - 1'b1;
          end
        end
        CONVERT: begin
          // gate rises conv_delay cycles after the cnv cycle
          if (delay_cnt == '0) begin
            state   <= READOUT;
            gate    <= 1'b1;
            bit_cnt <= last_bit;
          end else begin
            delay_cnt <= delay_cnt - 1'b1;
          end
        end
        READOUT: begin
          if (bit_cnt == '0) begin
            state <= IDLE;
            gate  <= 1'b0;
          end else begin
            bit_cnt <= bit_cnt - 1'b1;
          end
        end
        default: begin
          state <= IDLE;
          gate  <= 1'b0;
        end
      endcase
    end
  end

  // ***********************************************************************
  // checks
  // ***********************************************************************

  // the ADC must not see a conversion start while it shifts data out
  a_cnv_gate_excl: assert property (
    @(posedge s_axi_aclk) disable iff (!rst_n)
    !(cnv && gate)
  );

  // period too short for delay plus readout
  a_start_in_idle: assert property (
    @(posedge s_axi_aclk) disable iff (!rst_n)
    cnv_start |-> (state == IDLE)
  );

endmodule

/* verilog/adc_if_params.svh */
// compile-time configuration of the SAR ADC capture core
// ADC_RESOLUTION has to be even, two-lane mode splits a word in halves
// period and delay counters are CNT_W bits, so both top out at 2**CNT_W-1
// reset defaults obey cnv_period > conv_delay + ADC_RESOLUTION + 2

`ifndef ADC_IF_PARAMS_SVH
`define ADC_IF_PARAMS_SVH

// bits per conversion result
`define ADC_RESOLUTION 18

// register port geometry
`define REG_ADDR_W 4
`define REG_DATA_W 32

// width of period and delay counters
`define CNT_W 16

// values loaded on reset, in s_axi_aclk cycles
`define DEF_CNV_PERIOD 40
`define DEF_CONV_DELAY 4

// read back at address 5
`define CORE_VERSION 32'h0001_0200

`endif

/* verilog/adc_if_pkg.sv */
// types shared by the capture core blocks
// all widths come from the params header

`include "adc_if_params.svh"

package adc_if_pkg;

  // ***********************************************************************
  // data and register words
  // ***********************************************************************

  // one conversion result, MSB first on the lanes
  typedef logic [`ADC_RESOLUTION-1:0] adc_sample_t;

  // register port
  typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [`REG_DATA_W-1:0] reg_data_t;

  // cycle counts for conversion period and conversion delay
  typedef logic [`CNT_W-1:0] cycle_cnt_t;

  // ***********************************************************************
  // readout sequencing
  // ***********************************************************************

  // IDLE waits for cnv, CONVERT counts the delay, READOUT holds the gate
  typedef enum logic [1:0] {
    IDLE,
    CONVERT,
    READOUT
  } readout_state_t;

endpackage

/* verilog/adc_if_top.sv */
// top level of the SAR ADC capture core
// single clock domain, clk_gate qualifies s_axi_aclk as the ADC data clock
// register port is a one-cycle strobe interface, see adc_reg_bank

module adc_if_top
  import adc_if_pkg::*;
(
  input  logic        s_axi_aclk,
  input  logic        rst_n,

  // register port
  input  logic        reg_wr,
  input  logic        reg_rd,
  input  reg_addr_t   reg_addr,
  input  reg_data_t   reg_wdata,
  output reg_data_t   reg_rdata,
  output logic        reg_rvalid,

  // ADC side
  output logic        cnv,
  output logic        clk_gate,
  input  logic        da,
  input  logic        db,

  // sample stream
  output logic        adc_valid,
  output adc_sample_t adc_data
);

  // live configuration
  adc_cfg_if cfg_if ();

  // ***********************************************************************
  // blocks
  // ***********************************************************************

  adc_reg_bank i_reg_bank (
    .s_axi_aclk   (s_axi_aclk),
    .rst_n        (rst_n),
    .reg_wr       (reg_wr),
    .reg_rd       (reg_rd),
    .reg_addr     (reg_addr),
    .reg_wdata    (reg_wdata),
    .sample_valid (adc_valid),
    .sample       (adc_data),
    .reg_rdata    (reg_rdata),
    .reg_rvalid   (reg_rvalid),
    .cfg          (cfg_if.reg_side)
  );

  adc_cnv_timing i_cnv_timing (
    .s_axi_aclk (s_axi_aclk),
    .rst_n      (rst_n),
    .cfg        (cfg_if.timing_side),
    .cnv        (cnv),
    .gate       (clk_gate)
  );

  // lane mode comes straight from the live configuration
  adc_lane_deser i_lane_deser (
    .s_axi_aclk   (s_axi_aclk),
    .rst_n        (rst_n),
    .gate         (clk_gate),
    .two_lanes    (cfg_if.two_lanes),
    .da           (da),
    .db           (db),
    .sample_valid (adc_valid),
    .sample       (adc_data)
  );

endmodule

/* verilog/adc_lane_deser.sv */
// lane deserializer of the capture core
// one bit per lane per s_axi_aclk cycle, no DDR capture
// da holds odd bit positions and db even ones in two-lane mode
// two_lanes must not change while gate is high

`include "adc_if_params.svh"

module adc_lane_deser
  import adc_if_pkg::*;
(
  input  logic        s_axi_aclk,
  input  logic        rst_n,
  input  logic        gate,
  input  logic        two_lanes,
  input  logic        da,
  input  logic        db,
  output logic        sample_valid,
  output adc_sample_t sample
);

  localparam int RES = `ADC_RESOLUTION;

  adc_sample_t shift_reg;
  logic        gate_q;
  logic        gate_fall;

  // ***********************************************************************
  // bit capture
  // ***********************************************************************

  // ADC launches on the falling edge, bits land here on the next rising
  // edge for as long as gate was high in the cycle before
  always_ff @(posedge s_axi_aclk) begin
    if (gate) begin
      if (two_lanes) begin
        // MSB first, da on the odd position of each pair
        shift_reg <= {shift_reg[RES-3:0], da, db};
      end else begin
        shift_reg <= {shift_reg[RES-2:0], da};
      end
    end
  end

  // ***********************************************************************
  // word output
  // ***********************************************************************

  // last bit went in on the edge where gate dropped
  assign gate_fall = gate_q && !gate;

  always_ff @(posedge s_axi_aclk or negedge rst_n) begin
    if (!rst_n) begin
      gate_q       <= 1'b0;
      sample_valid <= 1'b0;
    end else begin
      gate_q       <= gate;
      sample_valid <= gate_fall;
    end
  end

  // word held until the next readout completes
  always_ff @(posedge s_axi_aclk) begin
    if (gate_fall) begin
      sample <= shift_reg;
    end
  end

  // ***********************************************************************
  // checks
  // ***********************************************************************

  // lane mode and gate length were fixed when the gate opened
  a_lanes_stable: assert property (
    @(posedge s_axi_aclk) disable iff (!rst_n)
    gate |-> $stable(two_lanes)
  );

endmodule

/* verilog/adc_reg_bank.sv */
// strobe-driven register file of the capture core
// single-cycle reg_wr and reg_rd, no back-pressure
// read data and reg_rvalid follow reg_rd by exactly one cycle
// unmapped reads return zero, writes to read-only addresses are dropped
// except address 3, where any write clears the sample count

`include "adc_if_params.svh"

module adc_reg_bank
  import adc_if_pkg::*;
(
  input  logic        s_axi_aclk,
  input  logic        rst_n,
  input  logic        reg_wr,
  input  logic        reg_rd,
  input  reg_addr_t   reg_addr,
  input  reg_data_t   reg_wdata,
  input  logic        sample_valid,
  input  adc_sample_t sample,
  output reg_data_t   reg_rdata,
  output logic        reg_rvalid,
  adc_cfg_if.reg_side cfg
);

  // register map
  localparam reg_addr_t ADDR_CTRL    = reg_addr_t'(0);
  localparam reg_addr_t ADDR_PERIOD  = reg_addr_t'(1);
  localparam reg_addr_t ADDR_DELAY   = reg_addr_t'(2);
  localparam reg_addr_t ADDR_COUNT   = reg_addr_t'(3);
  localparam reg_addr_t ADDR_LAST    = reg_addr_t'(4);
  localparam reg_addr_t ADDR_VERSION = reg_addr_t'(5);

  logic        enable_r;
  logic        two_lanes_r;
  cycle_cnt_t  cnv_period_r;
  cycle_cnt_t  conv_delay_r;
  reg_data_t   sample_cnt;
  adc_sample_t last_sample;
  reg_data_t   rd_mux;

  // ***********************************************************************
  // writable configuration
  // ***********************************************************************

  always_ff @(posedge s_axi_aclk or negedge rst_n) begin
    if (!rst_n) begin
      enable_r     <= 1'b0;
      two_lanes_r  <= 1'b0;
      cnv_period_r <= cycle_cnt_t'(`DEF_CNV_PERIOD);
      conv_delay_r <= cycle_cnt_t'(`DEF_CONV_DELAY);
    end else if (reg_wr) begin
      case (reg_addr)
        ADDR_CTRL: begin
          enable_r    <= reg_wdata[0];
          two_lanes_r <= reg_wdata[1];
        end
        ADDR_PERIOD: cnv_period_r <= reg_wdata[`CNT_W-1:0];
        ADDR_DELAY:  conv_delay_r <= reg_wdata[`CNT_W-1:0];
        default: ;
      endcase
    end
  end

  // configuration goes out live to the datapath
  assign cfg.enable     = enable_r;
  assign cfg.two_lanes  = two_lanes_r;
  assign cfg.cnv_period = cnv_period_r;
  assign cfg.conv_delay = conv_delay_r;

  // ***********************************************************************
  // status, sample count and last sample
  // ***********************************************************************

  // clear wins over a sample arriving in the same cycle
  always_ff @(posedge s_axi_aclk or negedge rst_n) begin
    if (!rst_n) begin
      sample_cnt <= '0;
    end else if (reg_wr && (reg_addr == ADDR_COUNT)) begin
      sample_cnt <= '0;
    end else if (sample_valid) begin
      sample_cnt <= sample_cnt + 1'b1;
    end
  end

  always_ff @(posedge s_axi_aclk or negedge rst_n) begin
    if (!rst_n) begin
      last_sample <= '0;
    end else if (sample_valid) begin
      last_sample <= sample;
    end
  end

  // ***********************************************************************
  // read path
  // ***********************************************************************

  // narrower fields are zero-extended to the register word
  always_comb begin
    case (reg_addr)
      ADDR_CTRL:    rd_mux = reg_data_t'({two_lanes_r, enable_r});
      ADDR_PERIOD:  rd_mux = reg_data_t'(cnv_period_r);
      ADDR_DELAY:   rd_mux = reg_data_t'(conv_delay_r);
      ADDR_COUNT:   rd_mux = sample_cnt;
      ADDR_LAST:    rd_mux = reg_data_t'(last_sample);
      ADDR_VERSION: rd_mux = reg_data_t'(`CORE_VERSION);
      default:      rd_mux = '0;
    endcase
  end

  always_ff @(posedge s_axi_aclk or negedge rst_n) begin
    if (!rst_n) begin
      reg_rvalid <= 1'b0;
    end else begin
      reg_rvalid <= reg_rd;
    end
  end

  // data only captured on a read strobe
  always_ff @(posedge s_axi_aclk) begin
    if (reg_rd) begin
      reg_rdata <= rd_mux;
    end
  end

endmodule
